/* design/bp_settings.svh */
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// index widths of the predictor tables.
`define BP_PHT_BITS 6
`define BP_BTB_BITS 6
`define BP_BIT_BITS 7

// return stack pointer width, 16 entries.
`define BP_RAS_BITS 4

// fixed fetch addresses.
`define BP_EXC_VECTOR   32'hbfc00380
`define BP_RESET_VECTOR 32'hbfc00000

`endif

/* design/cpu_types_pkg.sv */
`default_nettype none
`include "bp_settings.svh"

package cpu_types_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // one instruction and one fetch bundle, in bytes.
    localparam word_t INSTR_BYTES  = 32'd4;
    localparam word_t BUNDLE_BYTES = 32'd8;

    localparam addr_t RESET_VECTOR = `BP_RESET_VECTOR;
    localparam addr_t EXC_VECTOR   = `BP_EXC_VECTOR;

endpackage

`default_nettype wire

/* design/bp_pkg.sv */
`default_nettype none
`include "bp_settings.svh"

package bp_pkg;
    import cpu_types_pkg::*;

    typedef logic [1:0]                pht_ctr_t;
    typedef logic [7:0]                ras_cnt_t;
    typedef logic [`BP_PHT_BITS-1:0]   pht_idx_t;
    typedef logic [`BP_BTB_BITS-1:0]   btb_idx_t;
    typedef logic [`BP_BIT_BITS-1:0]   bit_idx_t;
    typedef logic [`BP_RAS_BITS-1:0]   ras_ptr_t;

    localparam pht_ctr_t PHT_WEAK_NT = 2'd1;
    localparam pht_ctr_t PHT_WEAK_T  = 2'd2;

    // all indices end at pc bit 13.
    function automatic pht_idx_t pht_index(input addr_t pc);
        return pc[13 -: `BP_PHT_BITS];
    endfunction

    function automatic btb_idx_t btb_index(input addr_t pc);
        return pc[13 -: `BP_BTB_BITS];
    endfunction

    function automatic bit_idx_t bit_index(input addr_t pc);
        return pc[13 -: `BP_BIT_BITS];
    endfunction

    // saturating step of a direction counter.
    function automatic pht_ctr_t pht_step(input pht_ctr_t ctr, input logic up);
        if (up) begin
            return (ctr == 2'd3) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'd0) ? ctr : ctr - 2'd1;
    endfunction

endpackage

`default_nettype wire

/* design/bru_update_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bru_update_if;
    import cpu_types_pkg::*;

    logic  valid;
    logic  taken;
    logic  is_call;
    logic  is_ret;
    addr_t ins_pc;
    addr_t target;

    // driven by the branch unit side.
    modport source (
        output valid, taken, is_call, is_ret, ins_pc, target
    );

    // watched by the predictor tables.
    modport monitor (
        input valid, taken, is_call, is_ret, ins_pc, target
    );

endinterface

`default_nettype wire

/* design/bp_direction_table.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_direction_table (
    input  logic                 clk,
    input  logic                 resetn,
    bru_update_if.monitor        upd,
    input  cpu_types_pkg::addr_t fetch_pc,
    output logic                 predict_taken
);
    import cpu_types_pkg::*;
    import bp_pkg::*;

    localparam int DEPTH = 2 ** $bits(pht_idx_t);

    pht_ctr_t pht [DEPTH];
    addr_t    train_pc;
    logic     second_slot;
    pht_idx_t train_idx;
    pht_idx_t slot0_idx;
    pht_idx_t read_idx;

    // a second-slot branch trains the entry of the following bundle.
    assign second_slot = upd.ins_pc[2];
    assign train_pc    = second_slot ? upd.ins_pc + INSTR_BYTES : upd.ins_pc;
    assign train_idx   = pht_index(train_pc);
    assign slot0_idx   = pht_index(upd.ins_pc);

    assign read_idx      = pht_index(fetch_pc);
    assign predict_taken = (pht[read_idx] >= PHT_WEAK_T);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < DEPTH; i++) begin
                pht[i] <= PHT_WEAK_NT;
            end
        end else if (upd.valid) begin
            pht[train_idx] <= pht_step(pht[train_idx], upd.taken);
            // own bundle entry is weakened, this wins when the two alias.
            if (second_slot) begin
                pht[slot0_idx] <= pht_step(pht[slot0_idx], 1'b0);
            end
        end
    end

endmodule

`default_nettype wire

/* design/bp_target_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_target_buffer (
    input  logic                 clk,
    input  logic                 resetn,
    bru_update_if.monitor        upd,
    input  logic                 f2_valid,
    input  cpu_types_pkg::addr_t f2_pc,
    input  logic                 f2_is_ret,
    input  cpu_types_pkg::addr_t fetch_pc,
    output cpu_types_pkg::addr_t target,
    output logic                 is_ret
);
    import cpu_types_pkg::*;
    import bp_pkg::*;

    localparam int BTB_DEPTH = 2 ** $bits(btb_idx_t);
    localparam int BIT_DEPTH = 2 ** $bits(bit_idx_t);

    addr_t    btb     [BTB_DEPTH];
    logic     ret_bit [BIT_DEPTH];
    addr_t    train_pc;
    btb_idx_t train_idx;
    btb_idx_t slot0_idx;

    assign train_pc  = upd.ins_pc[2] ? upd.ins_pc + INSTR_BYTES : upd.ins_pc;
    assign train_idx = btb_index(train_pc);
    assign slot0_idx = btb_index(upd.ins_pc);

    assign target = btb[btb_index(fetch_pc)];
    assign is_ret = ret_bit[bit_index(fetch_pc)];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < BTB_DEPTH; i++) begin
                btb[i] <= '0;
            end
        end else if (upd.valid) begin
            btb[train_idx] <= upd.target;
            if (upd.ins_pc[2]) begin
                btb[slot0_idx] <= '0;
            end
        end
    end

    // return marks come from fetch stage 2.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < BIT_DEPTH; i++) begin
                ret_bit[i] <= 1'b0;
            end
        end else if (f2_valid) begin
            ret_bit[bit_index(f2_pc)] <= f2_is_ret;
        end
    end

endmodule

`default_nettype wire

/* design/bp_return_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_return_stack (
    input  logic                 clk,
    input  logic                 resetn,
    bru_update_if.monitor        upd,
    output cpu_types_pkg::addr_t top_pc,
    output logic                 top_valid
);
    import cpu_types_pkg::*;
    import bp_pkg::*;

    localparam int DEPTH = 2 ** $bits(ras_ptr_t);

    addr_t    ras_pc  [DEPTH];
    ras_cnt_t ras_cnt [DEPTH];
    ras_ptr_t top;
    ras_ptr_t push_ptr;
    addr_t    ret_addr;
    logic     repeat_call;

    // return lands after the delay slot.
    assign ret_addr    = upd.ins_pc + BUNDLE_BYTES;
    assign push_ptr    = top + 1'b1;
    assign repeat_call = (ras_pc[top] == ret_addr) && (ras_cnt[top] != '1);

    assign top_pc    = ras_pc[top];
    assign top_valid = |ras_pc[top];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            top <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                ras_pc[i]  <= '0;
                ras_cnt[i] <= '0;
            end
        end else if (upd.valid) begin
            if (upd.is_ret) begin
                if (ras_cnt[top] != '0) begin
                    ras_cnt[top] <= ras_cnt[top] - 1'b1;
                end else begin
                    ras_pc[top] <= '0;
                    top         <= top - 1'b1;
                end
            end else if (upd.is_call) begin
                if (repeat_call) begin
                    ras_cnt[top] <= ras_cnt[top] + 1'b1;
                end else begin
                    // pointer wraps to slot 0 when the stack is full.
                    ras_pc[push_ptr]  <= ret_addr;
                    ras_cnt[push_ptr] <= '0;
                    top               <= push_ptr;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/fetch_pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 pc_ready,
    output logic                 pc_valid,
    output cpu_types_pkg::addr_t pc,
    input  logic                 predict_taken,
    input  cpu_types_pkg::addr_t btb_target,
    input  logic                 is_ret,
    input  cpu_types_pkg::addr_t ras_pc,
    input  logic                 ras_valid,
    input  logic                 exc_flush,
    input  logic                 eret,
    input  cpu_types_pkg::addr_t epc,
    input  logic                 mispredict,
    input  cpu_types_pkg::addr_t recover_pc,
    input  logic                 d_flush,
    input  cpu_types_pkg::addr_t d_flush_pc,
    input  logic                 f2_flush,
    input  cpu_types_pkg::addr_t f2_flush_pc,
    input  logic                 no_ds,
    input  cpu_types_pkg::addr_t no_ds_pc,
    output logic                 bp_taken,
    output cpu_types_pkg::addr_t bp_target
);
    import cpu_types_pkg::*;

    addr_t fall_through;
    addr_t raw_target;
    logic  raw_taken;
    addr_t next_pc;
    logic  redirect;

    // ########################################################################
    // prediction
    // ########################################################################

    assign fall_through = {pc[31:3], 3'b000} + BUNDLE_BYTES;
    assign raw_taken    = (is_ret && ras_valid) || predict_taken;
    assign raw_target   = (is_ret && ras_valid) ? ras_pc : btb_target;

    // an empty target entry falls through.
    assign bp_taken  = raw_taken && (raw_target != '0);
    assign bp_target = bp_taken ? raw_target : fall_through;

    // ########################################################################
    // redirects, highest priority first
    // ########################################################################

    always_comb begin
        redirect = 1'b1;
        if (exc_flush) begin
            next_pc = EXC_VECTOR;
        end else if (eret) begin
            next_pc = epc;
        end else if (mispredict) begin
            next_pc = recover_pc;
        end else if (d_flush) begin
            next_pc = d_flush_pc;
        end else if (f2_flush) begin
            next_pc = f2_flush_pc;
        end else if (no_ds) begin
            next_pc = no_ds_pc + BUNDLE_BYTES;
        end else begin
            redirect = 1'b0;
            next_pc  = bp_target;
        end
    end

    // a redirect drops the pending fetch, so it ignores pc_ready.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc       <= RESET_VECTOR;
            pc_valid <= 1'b0;
        end else begin
            pc_valid <= 1'b1;
            if (redirect || (pc_valid && pc_ready)) begin
                pc <= next_pc;
            end
        end
    end

endmodule

`default_nettype wire

/* design/branch_predict_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predict_unit (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 pc_ready,
    output logic                 pc_valid,
    output cpu_types_pkg::addr_t pc,
    input  logic                 exc_flush,
    input  logic                 eret,
    input  cpu_types_pkg::addr_t epc,
    input  logic                 mispredict,
    input  cpu_types_pkg::addr_t recover_pc,
    input  logic                 d_flush,
    input  cpu_types_pkg::addr_t d_flush_pc,
    input  logic                 f2_flush,
    input  cpu_types_pkg::addr_t f2_flush_pc,
    input  logic                 no_ds,
    input  cpu_types_pkg::addr_t no_ds_pc,
    output logic                 bp_taken,
    output cpu_types_pkg::addr_t bp_target,
    input  logic                 upd_valid,
    input  logic                 upd_taken,
    input  logic                 upd_is_call,
    input  logic                 upd_is_ret,
    input  cpu_types_pkg::addr_t upd_pc,
    input  cpu_types_pkg::addr_t upd_target,
    input  logic                 f2_valid,
    input  cpu_types_pkg::addr_t f2_pc,
    input  logic                 f2_is_ret
);
    import cpu_types_pkg::*;

    logic  predict_taken;
    addr_t btb_target;
    logic  is_ret;
    addr_t ras_pc;
    logic  ras_valid;

    // ########################################################################
    // branch unit training event
    // ########################################################################

    bru_update_if upd ();

    assign upd.valid   = upd_valid;
    assign upd.taken   = upd_taken;
    assign upd.is_call = upd_is_call;
    assign upd.is_ret  = upd_is_ret;
    assign upd.ins_pc  = upd_pc;
    assign upd.target  = upd_target;

    // ########################################################################
    // tables and pc generation
    // ########################################################################

    bp_direction_table bp_direction_table_i (
        .clk           (clk),
        .resetn        (resetn),
        .upd           (upd.monitor),
        .fetch_pc      (pc),
        .predict_taken (predict_taken)
    );

    bp_target_buffer bp_target_buffer_i (
        .clk       (clk),
        .resetn    (resetn),
        .upd       (upd.monitor),
        .f2_valid  (f2_valid),
        .f2_pc     (f2_pc),
        .f2_is_ret (f2_is_ret),
        .fetch_pc  (pc),
        .target    (btb_target),
        .is_ret    (is_ret)
    );

    bp_return_stack bp_return_stack_i (
        .clk       (clk),
        .resetn    (resetn),
        .upd       (upd.monitor),
        .top_pc    (ras_pc),
        .top_valid (ras_valid)
    );

    fetch_pc_gen fetch_pc_gen_i (
        .clk           (clk),
        .resetn        (resetn),
        .pc_ready      (pc_ready),
        .pc_valid      (pc_valid),
        .pc            (pc),
        .predict_taken (predict_taken),
        .btb_target    (btb_target),
        .is_ret        (is_ret),
        .ras_pc        (ras_pc),
        .ras_valid     (ras_valid),
        .exc_flush     (exc_flush),
        .eret          (eret),
        .epc           (epc),
        .mispredict    (mispredict),
        .recover_pc    (recover_pc),
        .d_flush       (d_flush),
        .d_flush_pc    (d_flush_pc),
        .f2_flush      (f2_flush),
        .f2_flush_pc   (f2_flush_pc),
        .no_ds         (no_ds),
        .no_ds_pc      (no_ds_pc),
        .bp_taken      (bp_taken),
        .bp_target     (bp_target)
    );

endmodule

`default_nettype wire

/* tests/tb_branch_predict_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bp_settings.svh"

module tb_branch_predict_unit;
    import cpu_types_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int SEQ_CYCLES     = 40;
    localparam int REDIRECT_ITERS = 600;
    // tests 2 to 4 take well under 80 cycles together.
    localparam int MAX_CYCLES = 2 * (RESET_CYCLES + SEQ_CYCLES + 80 + 2 * REDIRECT_ITERS);
    localparam int PHT_N = 1 << `BP_PHT_BITS;
    localparam int BTB_N = 1 << `BP_BTB_BITS;
    localparam int BIT_N = 1 << `BP_BIT_BITS;
    localparam int RAS_N = 1 << `BP_RAS_BITS;

    logic  clk, resetn, pc_ready, pc_valid, bp_taken;
    logic  exc_flush, eret, mispredict, d_flush, f2_flush, no_ds;
    logic  upd_valid, upd_taken, upd_is_call, upd_is_ret, f2_valid, f2_is_ret;
    addr_t pc, bp_target, epc, recover_pc, d_flush_pc, f2_flush_pc, no_ds_pc;
    addr_t upd_pc, upd_target, f2_pc;

    // reference model state.
    logic [1:0]  pht_m [PHT_N];
    addr_t       btb_m [BTB_N];
    logic        rbit_m [BIT_N];
    addr_t       ras_pc_m [RAS_N];
    int          ras_cnt_m [RAS_N];
    int          top_m;
    addr_t       pc_m;
    logic        valid_m;

    logic [31:0] lfsr_state;
    logic        checking;
    int          errors, checks, test_base, cycles;
    addr_t       prev_pc, expected, held;
    logic        prev_acc, hit;
    logic [5:0]  mask;

    branch_predict_unit branch_predict_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr x^32 + x^22 + x^2 + x + 1 stepped once per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // index field of the given width ending at pc bit 13.
    function automatic int field_idx(input addr_t a, input int bits);
        return int'((a >> (14 - bits)) & ((32'd1 << bits) - 32'd1));
    endfunction

    function automatic logic [1:0] saturate(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    function automatic void predict(input addr_t p, output logic tk, output addr_t tg);
        addr_t raw;
        logic  use_raw;
        use_raw = 1'b0;
        raw = '0;
        if (rbit_m[field_idx(p, `BP_BIT_BITS)] && ras_pc_m[top_m] != '0) begin
            use_raw = 1'b1;
            raw = ras_pc_m[top_m];
        end else if (pht_m[field_idx(p, `BP_PHT_BITS)] >= 2'd2) begin
            use_raw = 1'b1;
            raw = btb_m[field_idx(p, `BP_BTB_BITS)];
        end
        tk = use_raw && (raw != '0);
        tg = tk ? raw : {p[31:3], 3'b000} + 32'd8;
    endfunction

    // highest-priority redirect among the current inputs.
    function automatic void redirect_pc(output logic taken, output addr_t a);
        taken = 1'b1;
        a = '0;
        if (exc_flush) a = `BP_EXC_VECTOR;
        else if (eret) a = epc;
        else if (mispredict) a = recover_pc;
        else if (d_flush) a = d_flush_pc;
        else if (f2_flush) a = f2_flush_pc;
        else if (no_ds) a = no_ds_pc + 32'd8;
        else taken = 1'b0;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < PHT_N; i++) pht_m[i] = 2'd1;
        for (int i = 0; i < BTB_N; i++) btb_m[i] = '0;
        for (int i = 0; i < BIT_N; i++) rbit_m[i] = 1'b0;
        for (int i = 0; i < RAS_N; i++) begin
            ras_pc_m[i] = '0;
            ras_cnt_m[i] = 0;
        end
        top_m = 0;
        pc_m = `BP_RESET_VECTOR;
        valid_m = 1'b0;
    endtask

    task automatic advance_model();
        logic       tk, redir;
        addr_t      tg, ra, rd;
        int         pti, psi, bti, bsi;
        logic [1:0] old_t, old_s;
        predict(pc_m, tk, tg);
        redirect_pc(redir, rd);
        if (redir) pc_m = rd;
        else if (valid_m && pc_ready) pc_m = tg;
        valid_m = 1'b1;
        if (f2_valid) rbit_m[field_idx(f2_pc, `BP_BIT_BITS)] = f2_is_ret;
        if (!upd_valid) return;
        // a second-slot branch trains the next bundle and weakens its own.
        pti = field_idx(upd_pc[2] ? upd_pc + 32'd4 : upd_pc, `BP_PHT_BITS);
        psi = field_idx(upd_pc, `BP_PHT_BITS);
        bti = field_idx(upd_pc[2] ? upd_pc + 32'd4 : upd_pc, `BP_BTB_BITS);
        bsi = field_idx(upd_pc, `BP_BTB_BITS);
        old_t = pht_m[pti];
        old_s = pht_m[psi];
        pht_m[pti] = saturate(old_t, upd_taken);
        btb_m[bti] = upd_target;
        if (upd_pc[2]) begin
            pht_m[psi] = saturate(old_s, 1'b0);
            btb_m[bsi] = '0;
        end
        ra = upd_pc + 32'd8;
        if (upd_is_ret) begin
            if (ras_cnt_m[top_m] != 0) begin
                ras_cnt_m[top_m]--;
            end else begin
                ras_pc_m[top_m] = '0;
                top_m = (top_m - 1) & (RAS_N - 1);
            end
        end else if (upd_is_call) begin
            if (ras_pc_m[top_m] == ra && ras_cnt_m[top_m] != 255) begin
                ras_cnt_m[top_m]++;
            end else begin
                top_m = (top_m + 1) & (RAS_N - 1);
                ras_pc_m[top_m] = ra;
                ras_cnt_m[top_m] = 0;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!resetn) reset_model();
        else advance_model();
    end

    task automatic report_mismatch(input string name, input addr_t got, input addr_t exp);
        errors++;
        $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
    endtask

    // ########################################################################
    // checks against the model, mid cycle where outputs are settled
    // ########################################################################

    always @(negedge clk) begin : compare_outputs
        logic  tk;
        addr_t tg;
        if (checking) begin
            predict(pc_m, tk, tg);
            checks += 4;
            assert (pc_valid === valid_m) else report_mismatch("pc_valid", pc_valid, valid_m);
            assert (pc === pc_m) else report_mismatch("pc", pc, pc_m);
            assert (bp_taken === tk) else report_mismatch("bp_taken", bp_taken, tk);
            assert (bp_target === tg) else report_mismatch("bp_target", bp_target, tg);
        end
    end

    valid_low_after_reset: assert property (@(posedge clk) !resetn |=> !pc_valid)
        else report_mismatch("pc_valid", pc_valid, 1'b0);

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic idle_inputs();
        {exc_flush, eret, mispredict, d_flush, f2_flush, no_ds} = '0;
        {upd_valid, upd_taken, upd_is_call, upd_is_ret, f2_valid, f2_is_ret} = '0;
        {epc, recover_pc, d_flush_pc, f2_flush_pc, no_ds_pc} = '0;
        {upd_pc, upd_target, f2_pc} = '0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
        idle_inputs();
        pc_ready = 1'(take_bits(1));
    endtask

    task automatic send_update(input addr_t p, input addr_t t, input logic tk,
                               input logic call, input logic ret);
        next_cycle();
        {upd_valid, upd_taken, upd_is_call, upd_is_ret} = {1'b1, tk, call, ret};
        upd_pc = p;
        upd_target = t;
    endtask

    task automatic mark_return(input addr_t p);
        next_cycle();
        {f2_valid, f2_is_ret} = 2'b11;
        f2_pc = p;
    endtask

    // flush fetch2 to land pc on a bundle, then wait to mid cycle.
    task automatic steer_to(input addr_t p);
        next_cycle();
        f2_flush = 1'b1;
        f2_flush_pc = p;
        next_cycle();
        @(negedge clk);
    endtask

    task automatic expect_prediction(input logic tk, input addr_t tg);
        checks += 2;
        assert (bp_taken === tk) else report_mismatch("bp_taken", bp_taken, tk);
        assert (bp_target === tg) else report_mismatch("bp_target", bp_target, tg);
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s finished with %0d errors", num, name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        {errors, checks, test_base, cycles} = '0;
        checking = 1'b0;
        lfsr_state = 32'haa712e5e;
        resetn = 1'b0;
        pc_ready = 1'b0;
        idle_inputs();

        next_cycle();
        checking = 1'b1;
        repeat (RESET_CYCLES - 1) next_cycle();
        resetn = 1'b1;
        @(negedge clk);
        checks += 2;
        assert (pc_valid === 1'b0) else report_mismatch("pc_valid", pc_valid, 1'b0);
        assert (pc === `BP_RESET_VECTOR) else report_mismatch("pc", pc, `BP_RESET_VECTOR);
        prev_pc = pc;
        prev_acc = pc_valid && pc_ready;
        for (int i = 0; i < SEQ_CYCLES; i++) begin
            next_cycle();
            @(negedge clk);
            expected = prev_acc ? prev_pc + 32'd8 : prev_pc;
            checks++;
            assert (pc === expected) else report_mismatch("pc", pc, expected);
            prev_pc = pc;
            prev_acc = pc_valid && pc_ready;
        end
        finish_test(1, "reset and sequential fetch");

        repeat (2) send_update(32'h00001200, 32'h00003400, 1'b1, 1'b0, 1'b0);
        steer_to(32'h00001200);
        expect_prediction(1'b1, 32'h00003400);
        repeat (2) send_update(32'h00001200, 32'h00003400, 1'b0, 1'b0, 1'b0);
        steer_to(32'h00001200);
        expect_prediction(1'b0, 32'h00001208);
        finish_test(2, "direction training");

        // the branch after 22fc sits in the bundle at 2300 and trains another entry.
        repeat (2) send_update(32'h000022f8, 32'h00005000, 1'b1, 1'b0, 1'b0);
        send_update(32'h000022fc, 32'h00006000, 1'b1, 1'b0, 1'b0);
        steer_to(32'h000022f8);
        expect_prediction(1'b0, 32'h00002300);
        steer_to(32'h00002300);
        expect_prediction(1'b1, 32'h00006000);
        // one not-taken step from the weakened counter drops it below taken.
        send_update(32'h000022f8, 32'h00005000, 1'b0, 1'b0, 1'b0);
        steer_to(32'h000022f8);
        expect_prediction(1'b0, 32'h00002300);
        finish_test(3, "second-slot update");

        send_update(32'h00003010, 32'h00007000, 1'b1, 1'b1, 1'b0);
        mark_return(32'h00003800);
        steer_to(32'h00003800);
        expect_prediction(1'b1, 32'h00003018);
        repeat (2) send_update(32'h00003010, 32'h00007000, 1'b1, 1'b1, 1'b0);
        for (int k = 0; k < 3; k++) begin
            send_update(32'h00003900, 32'h00003018, 1'b1, 1'b0, 1'b1);
            steer_to(32'h00003800);
            expect_prediction(k < 2, (k < 2) ? 32'h00003018 : 32'h00003808);
        end
        finish_test(4, "return stack");

        for (int i = 0; i < REDIRECT_ITERS; i++) begin
            next_cycle();
            mask = 6'(take_bits(6));
            {exc_flush, eret, mispredict, d_flush, f2_flush, no_ds} = mask;
            epc = take_bits(32);
            recover_pc = take_bits(32);
            d_flush_pc = take_bits(32);
            f2_flush_pc = take_bits(32);
            no_ds_pc = take_bits(32);
            pc_ready = 1'b0;
            held = pc;
            redirect_pc(hit, expected);
            if (!hit) expected = held;
            next_cycle();
            @(negedge clk);
            checks++;
            assert (pc === expected) else report_mismatch("pc", pc, expected);
        end
        finish_test(5, "redirect priority");

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/cpu_types_pkg.sv
design/bp_pkg.sv
design/bru_update_if.sv
design/bp_direction_table.sv
design/bp_target_buffer.sv
design/bp_return_stack.sv
design/fetch_pc_gen.sv
design/branch_predict_unit.sv
tests/tb_branch_predict_unit.sv

/* Bender.yml */
package:
  name: branch_predict_unit

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_types_pkg.sv
      - design/bp_pkg.sv
      - design/bru_update_if.sv
      - design/bp_direction_table.sv
      - design/bp_target_buffer.sv
      - design/bp_return_stack.sv
      - design/fetch_pc_gen.sv
      - design/branch_predict_unit.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_branch_predict_unit.sv
